// File: logic/uart_pkg.sv
package uart_pkg;

    //////////////////////////////
    // Serial framing
    //////////////////////////////

    localparam int DATA_BITS = 8;                  // Payload bits per frame, LSB first

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // Position inside a frame, shared by the serializer and the deserializer
    typedef enum logic [2:0] {
        ph_idle,                                   // Line high, waiting
        ph_start,                                  // Start bit, line low
        ph_data,                                   // Data bits
        ph_parity,                                 // Optional even parity bit
        ph_stop                                    // Stop bit, line high
    } uart_phase_t;

    //////////////////////////////
    // Received frame
    //////////////////////////////

    typedef struct packed {
        uart_byte_t data;                          // Deserialized byte
        logic       parity_error;                  // Bad parity or bad stop bit
    } rx_frame_t;

    // Parity bit that makes the count of ones in data plus parity even
    function automatic logic even_parity(uart_byte_t data);
        return ^data;
    endfunction

endpackage

// File: logic/link_test_pkg.sv
package link_test_pkg;

    //////////////////////////////
    // Command bytes
    //////////////////////////////

    localparam uart_pkg::uart_byte_t cmd_turn_on  = 8'hEE;
    localparam uart_pkg::uart_byte_t cmd_turn_off = 8'h55;
    localparam uart_pkg::uart_byte_t cmd_toggle   = 8'hC3;

    localparam int NUM_CMDS = 3;                   // Length of the repeating cycle

    typedef logic [1:0] cmd_idx_t;

    // Maps the cycle position to the byte put on the line
    function automatic uart_pkg::uart_byte_t cmd_byte(cmd_idx_t idx);
        case (idx)
            2'd0:    return cmd_turn_on;
            2'd1:    return cmd_turn_off;
            default: return cmd_toggle;
        endcase
    endfunction

    //////////////////////////////
    // Sequencer and status
    //////////////////////////////

    typedef enum logic [1:0] {seq_hold, seq_send, seq_gap} seq_state_t;

    localparam int ERR_W = 5;
    localparam logic [ERR_W-1:0] ERR_MAX = '1;     // Counter saturates here

    typedef struct packed {
        logic [ERR_W-1:0] error_count;             // Bad frames seen, saturating
        logic             match_led;               // Last frame was good
        logic             mismatch_led;            // Last frame was bad
    } link_status_t;

endpackage

// File: logic/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 4,
    parameter int PARITY_EN    = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_tx,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                tx,
    output logic                tx_busy
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int BIT_W = $clog2(DATA_BITS);

    uart_phase_t      phase;
    logic [CNT_W-1:0] clk_cnt;                     // Cycles spent in the current bit
    logic [BIT_W-1:0] bit_cnt;                     // Data bit on the line
    uart_byte_t       shifter;                     // Data bits still to send
    logic             parity_bit;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= ph_idle;
            tx      <= 1'b1;                       // Line idles high
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (phase == ph_idle) begin
            if (start_tx) begin
                shifter    <= tx_data;
                parity_bit <= even_parity(tx_data);
                tx         <= 1'b0;                // Start bit
                tx_busy    <= 1'b1;
                clk_cnt    <= '0;
                phase      <= ph_start;
            end
        end else if (!bit_end) begin
            clk_cnt <= clk_cnt + 1'b1;
        end else begin
            clk_cnt <= '0;
            case (phase)
                ph_start: begin
                    tx      <= shifter[0];
                    shifter <= shifter >> 1;
                    bit_cnt <= '0;
                    phase   <= ph_data;
                end
                ph_data: begin
                    if (bit_cnt != BIT_W'(DATA_BITS - 1)) begin
                        tx      <= shifter[0];
                        shifter <= shifter >> 1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (PARITY_EN != 0) begin
                        tx    <= parity_bit;
                        phase <= ph_parity;
                    end else begin
                        tx    <= 1'b1;             // Straight to the stop bit
                        phase <= ph_stop;
                    end
                end
                ph_parity: begin
                    tx    <= 1'b1;
                    phase <= ph_stop;
                end
                default: begin
                    tx_busy <= 1'b0;               // Stop bit done, line stays high
                    phase   <= ph_idle;
                end
            endcase
        end
    end

    // The sequencer must wait for the serializer before starting a new frame
    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst) start_tx |-> !tx_busy
    );

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 4,
    parameter int PARITY_EN    = 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               link_rst,
    input  logic               rx,
    output logic               rx_done,
    output uart_pkg::rx_frame_t rx_frame
);

    import uart_pkg::*;

    localparam int CNT_W    = $clog2(CLKS_PER_BIT + 1);
    localparam int BIT_W    = $clog2(DATA_BITS);
    localparam int HALF_BIT = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

    //////////////////////////////
    // Input synchronizer
    //////////////////////////////

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;                                 // Last synchronized level, for edges

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    //////////////////////////////
    // Frame sampling
    //////////////////////////////

    uart_phase_t      phase;
    logic [CNT_W-1:0] clk_cnt;
    logic [BIT_W-1:0] bit_cnt;
    uart_byte_t       shifter;                     // Data bits collected so far
    logic             parity_bit;
    logic             mid_bit;

    // Start bit is timed to its middle, every later bit a whole bit apart
    assign mid_bit = (phase == ph_start) ? (clk_cnt == CNT_W'(HALF_BIT - 1))
                                         : (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst || link_rst) begin
            phase   <= ph_idle;
            rx_done <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            rx_done <= 1'b0;
            if (phase == ph_idle) begin
                if (rx_prev && !rx_sync) begin     // Falling edge opens a frame
                    clk_cnt <= '0;
                    phase   <= ph_start;
                end
            end else if (!mid_bit) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                case (phase)
                    ph_start: begin
                        bit_cnt <= '0;
                        phase   <= rx_sync ? ph_idle : ph_data;  // Glitch, not a start bit
                    end
                    ph_data: begin
                        shifter <= {rx_sync, shifter[DATA_BITS-1:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            phase <= (PARITY_EN != 0) ? ph_parity : ph_stop;
                        end
                    end
                    ph_parity: begin
                        parity_bit <= rx_sync;
                        phase      <= ph_stop;
                    end
                    default: begin
                        rx_frame.data         <= shifter;
                        rx_frame.parity_error <= !rx_sync ||
                            ((PARITY_EN != 0) && (parity_bit != even_parity(shifter)));
                        rx_done               <= 1'b1;
                        phase                 <= ph_idle;
                    end
                endcase
            end
        end
    end

    // A frame takes many bit times, so completions can never be back to back
    a_done_single: assert property (
        @(posedge clk) disable iff (rst) rx_done |=> !rx_done
    );

endmodule

// File: logic/link_sequencer.sv
`timescale 1ns/10ps

module link_sequencer #(
    parameter int HOLD_CYCLES  = 20,
    parameter int BURST_FRAMES = 6,
    parameter int GAP_CYCLES   = 60
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_busy,
    output logic                 start_tx,
    output logic                 sent_valid,
    output logic                 link_rst,
    output uart_pkg::uart_byte_t tx_data,
    output uart_pkg::uart_byte_t sent_data,
    output logic                 gap
);

    import link_test_pkg::*;

    localparam int CNT_MAX = (HOLD_CYCLES > GAP_CYCLES) ? HOLD_CYCLES : GAP_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam int FRM_W   = $clog2(BURST_FRAMES + 1);

    seq_state_t       state;
    logic [CNT_W-1:0] cycle_cnt;
    logic [FRM_W-1:0] frame_cnt;                   // Frames issued in this burst
    cmd_idx_t         cmd_idx;                     // Kept across bursts
    logic             tx_free;
    logic             issue;

    // The busy flag rises a cycle after the strobe, so the strobe also blocks
    assign tx_free = !tx_busy && !start_tx;
    assign issue   = (state == seq_send) && (frame_cnt != FRM_W'(BURST_FRAMES)) && tx_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= seq_hold;
            cycle_cnt <= '0;
            frame_cnt <= '0;
            cmd_idx   <= '0;
            start_tx  <= 1'b0;
        end else begin
            start_tx <= issue;
            case (state)
                seq_hold: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == CNT_W'(HOLD_CYCLES - 1)) begin
                        cycle_cnt <= '0;
                        frame_cnt <= '0;
                        state     <= seq_send;
                    end
                end
                seq_send: begin
                    if (issue) begin
                        frame_cnt <= frame_cnt + 1'b1;
                        cmd_idx   <= (cmd_idx == cmd_idx_t'(NUM_CMDS - 1)) ? '0 : cmd_idx + 1'b1;
                    end else if (frame_cnt == FRM_W'(BURST_FRAMES) && tx_free) begin
                        cycle_cnt <= '0;           // Last frame has left the line
                        state     <= seq_gap;
                    end
                end
                default: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == CNT_W'(GAP_CYCLES - 1)) begin
                        cycle_cnt <= '0;
                        frame_cnt <= '0;
                        state     <= seq_send;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tx_data <= cmd_byte(cmd_idx);
        end
    end

    assign sent_valid = start_tx;                  // Checker learns each byte as it goes out
    assign sent_data  = tx_data;
    assign link_rst   = (state == seq_hold);
    assign gap        = (state == seq_gap);

endmodule

// File: logic/frame_checker.sv
`timescale 1ns/10ps

module frame_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       link_rst,
    input  logic                       sent_valid,
    input  logic                       rx_done,
    input  logic                       gap,
    input  uart_pkg::uart_byte_t       sent_data,
    input  uart_pkg::rx_frame_t        rx_frame,
    output link_test_pkg::link_status_t status
);

    import uart_pkg::*;
    import link_test_pkg::*;

    localparam int DEPTH = 4;
    localparam int PTR_W = $clog2(DEPTH);

    //////////////////////////////
    // In-flight byte queue
    //////////////////////////////

    uart_byte_t       queue_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   level;                       // Entries held
    logic             bad_frame;

    always_ff @(posedge clk) begin
        if (sent_valid) begin
            queue_mem[wr_ptr] <= sent_data;
        end
    end

    assign bad_frame = (rx_frame.data != queue_mem[rd_ptr]) || rx_frame.parity_error;

    always_ff @(posedge clk) begin
        if (rst || link_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            status <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(sent_valid);
            rd_ptr <= rd_ptr + PTR_W'(rx_done);
            level  <= level + (PTR_W + 1)'(sent_valid) - (PTR_W + 1)'(rx_done);
            if (rx_done) begin
                status.match_led    <= !bad_frame;
                status.mismatch_led <= bad_frame;
                if (bad_frame && status.error_count != ERR_MAX) begin
                    status.error_count <= status.error_count + 1'b1;
                end
            end else if (gap) begin
                status.match_led    <= 1'b0;   // Lights go dark between bursts
                status.mismatch_led <= 1'b0;
            end
        end
    end

    // Every received frame must pair with a byte the sequencer sent
    a_pop_not_empty: assert property (
        @(posedge clk) disable iff (rst || link_rst) rx_done |-> level != '0
    );

    // Bytes in flight never exceed the queue depth
    a_push_not_full: assert property (
        @(posedge clk) disable iff (rst || link_rst)
        (sent_valid && !rx_done) |-> level != (PTR_W + 1)'(DEPTH)
    );

endmodule

// File: logic/link_tester_top.sv
`timescale 1ns/10ps

module link_tester_top #(
    parameter int CLKS_PER_BIT = 4,
    parameter int PARITY_EN    = 1,
    parameter int HOLD_CYCLES  = 20,
    parameter int BURST_FRAMES = 6,
    parameter int GAP_CYCLES   = 60
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rx,
    output logic                        tx,
    output link_test_pkg::link_status_t status
);

    import uart_pkg::*;

    //////////////////////////////
    // Stage wiring
    //////////////////////////////

    logic       start_tx;
    logic       tx_busy;
    logic       sent_valid;
    logic       link_rst;                          // High while the link is held
    logic       gap;
    logic       rx_done;
    uart_byte_t tx_data;
    uart_byte_t sent_data;
    rx_frame_t  rx_frame;

    link_sequencer #(
        .HOLD_CYCLES (HOLD_CYCLES),
        .BURST_FRAMES(BURST_FRAMES),
        .GAP_CYCLES  (GAP_CYCLES)
    ) sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .tx_busy   (tx_busy),
        .start_tx  (start_tx),
        .sent_valid(sent_valid),
        .link_rst  (link_rst),
        .tx_data   (tx_data),
        .sent_data (sent_data),
        .gap       (gap)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PARITY_EN   (PARITY_EN)
    ) tx_i (
        .clk     (clk),
        .rst     (rst),
        .start_tx(start_tx),
        .tx_data (tx_data),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PARITY_EN   (PARITY_EN)
    ) rx_i (
        .clk     (clk),
        .rst     (rst),
        .link_rst(link_rst),
        .rx      (rx),
        .rx_done (rx_done),
        .rx_frame(rx_frame)
    );

    frame_checker checker_i (
        .clk       (clk),
        .rst       (rst),
        .link_rst  (link_rst),
        .sent_valid(sent_valid),
        .rx_done   (rx_done),
        .gap       (gap),
        .sent_data (sent_data),
        .rx_frame  (rx_frame),
        .status    (status)
    );

endmodule

// File: tb/tb_link_tester.sv
`timescale 1ns/10ps

module tb_link_tester;

    import uart_pkg::*;
    import link_test_pkg::*;

    localparam int CPB        = 4;
    localparam int PE         = 1;
    localparam int HOLD       = 20;
    localparam int BF         = 6;
    localparam int GAP        = 60;
    localparam int FRAME_CYC  = (10 + PE) * CPB;   // Cycles per frame on the line
    localparam int BURST_IDLE = 20;                // Idle run longer than this splits bursts
    localparam int MAX_TESTS  = 16;
    localparam int ALL_FRAMES = 255;

    logic         clk;
    logic         rst;
    logic         rx;
    logic         tx;
    link_status_t status;

    int test_bursts [MAX_TESTS];
    int test_frame [MAX_TESTS];
    int test_bit [MAX_TESTS];
    int test_expect [MAX_TESTS];
    int num_tests;
    int cur_frame;                                 // Frame to corrupt in the running test
    int cur_bit;
    int test_errors;
    int pass_cnt;
    int fail_cnt;
    longint cycle_cnt;
    longint cycle_limit;

    // Line monitor state
    bit         prev_tx;
    bit         in_frame;
    int         pos;
    int         frame_num;
    int         idle_run;
    int         burst_frames;
    int         frames_decoded;
    uart_byte_t cur_byte;
    bit         par_seen;
    uart_byte_t cmd_seq [3] = '{8'hEE, 8'h55, 8'hC3};

    // Status model state
    int done_cnt;
    int exp_err;
    bit upd_pending;
    bit exp_bad;

    link_tester_top #(
        .CLKS_PER_BIT(CPB),
        .PARITY_EN   (PE),
        .HOLD_CYCLES (HOLD),
        .BURST_FRAMES(BF),
        .GAP_CYCLES  (GAP)
    ) dut_i (
        .clk   (clk),
        .rst   (rst),
        .rx    (rx),
        .tx    (tx),
        .status(status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic bit frame_corrupted(int n);
        return (cur_frame == ALL_FRAMES) || (cur_frame != 0 && n == cur_frame);
    endfunction

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Loopback line and decoder
    //////////////////////////////

    always @(posedge clk) begin
        int slot;
        bit flip;
        if (rst) begin
            rx             <= 1'b1;
            prev_tx        = 1'b1;
            in_frame       = 1'b0;
            pos            = 0;
            frame_num      = 0;
            idle_run       = 0;
            burst_frames   = 0;
            frames_decoded = 0;
        end else begin
            if (!in_frame && prev_tx && !tx) begin
                if (burst_frames > 0 && idle_run > BURST_IDLE) begin
                    if (burst_frames != BF) begin
                        $display("MISMATCH frames_per_burst expected %h got %h", BF, burst_frames);
                        test_errors++;
                    end
                    if (status.match_led !== 1'b0 || status.mismatch_led !== 1'b0) begin
                        $display("MISMATCH match_led,mismatch_led expected 0,0 got %h,%h",
                                 status.match_led, status.mismatch_led);
                        test_errors++;             // Lights stay dark through the gap
                    end
                    burst_frames = 0;
                end
                in_frame = 1'b1;
                pos      = 0;
                frame_num++;
                cur_byte = '0;
            end else if (in_frame) begin
                pos++;
            end else begin
                idle_run++;
            end
            if (in_frame && (pos % CPB) == CPB / 2) begin   // Middle of a bit
                slot = pos / CPB;
                if (slot >= 1 && slot <= 8) begin
                    cur_byte[slot-1] = tx;
                end else if (PE != 0 && slot == 9) begin
                    par_seen = tx;
                end else if (slot == 9 + PE) begin
                    if (tx !== 1'b1) begin
                        $display("MISMATCH tx_stop_bit expected 1 got %h", tx);
                        test_errors++;
                    end
                    if (PE != 0 && ((^cur_byte) ^ par_seen) != 1'b0) begin
                        $display("MISMATCH tx_parity expected %h got %h", ^cur_byte, par_seen);
                        test_errors++;
                    end
                    if (cur_byte != cmd_seq[(frame_num - 1) % 3]) begin
                        $display("MISMATCH tx_byte expected %h got %h",
                                 cmd_seq[(frame_num - 1) % 3], cur_byte);
                        test_errors++;
                    end
                end
            end
            flip = in_frame && frame_corrupted(frame_num) &&
                   pos >= (1 + cur_bit) * CPB && pos < (2 + cur_bit) * CPB;
            rx <= tx ^ flip;                       // Inverts rx inside the chosen bit only
            if (in_frame && pos == FRAME_CYC - 1) begin
                in_frame = 1'b0;
                idle_run = 0;
                burst_frames++;
                frames_decoded++;
            end
            prev_tx = tx;
        end
    end

    //////////////////////////////
    // Status model
    //////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            done_cnt    = 0;
            exp_err     = 0;
            upd_pending = 1'b0;
        end else begin
            if (upd_pending) begin                 // Status has settled one cycle after done
                if (status.error_count !== exp_err[4:0]) begin
                    $display("MISMATCH error_count expected %h got %h", exp_err[4:0],
                             status.error_count);
                    test_errors++;
                end
                if (status.match_led !== !exp_bad || status.mismatch_led !== exp_bad) begin
                    $display("MISMATCH match_led,mismatch_led expected %h,%h got %h,%h",
                             !exp_bad, exp_bad, status.match_led, status.mismatch_led);
                    test_errors++;
                end
                upd_pending = 1'b0;
            end
            if (dut_i.rx_done) begin
                done_cnt++;
                exp_bad = frame_corrupted(done_cnt);
                if (exp_bad && exp_err < 31) begin
                    exp_err++;
                end
                upd_pending = 1'b1;
            end
        end
    end

    task automatic run_test(int t);
        int frames;
        frames      = test_bursts[t] * BF;
        cur_frame   = test_frame[t];
        cur_bit     = test_bit[t];
        test_errors = 0;
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (tx !== 1'b1) begin
            $display("MISMATCH tx expected 1 got %h", tx);
            test_errors++;
        end
        if (status !== '0) begin
            $display("MISMATCH status expected 00 got %h", status);
            test_errors++;
        end
        repeat (HOLD) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                $display("MISMATCH tx expected 1 got %h", tx);
                test_errors++;
            end
        end
        while (done_cnt < frames) @(negedge clk);
        @(negedge clk);
        if (frames_decoded != frames) begin
            $display("MISMATCH frames_on_tx expected %h got %h", frames, frames_decoded);
            test_errors++;
        end
        if (burst_frames != BF) begin
            $display("MISMATCH frames_per_burst expected %h got %h", BF, burst_frames);
            test_errors++;
        end
        if (status.error_count !== test_expect[t][4:0]) begin
            $display("MISMATCH error_count expected %h got %h", test_expect[t][4:0],
                     status.error_count);
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Test %0d: bursts %0d frame %0d bit %0d error_count %0d, %s", t,
                 test_bursts[t], cur_frame, cur_bit, status.error_count,
                 (test_errors == 0) ? "ok" : "failed");
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        rst         = 1'b1;
        rx          = 1'b1;
        cur_frame   = 0;
        cur_bit     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        num_tests   = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        fd = $fopen("tb/testdata_link.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/testdata_link.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %d %d %d", test_bursts[num_tests],
                            test_frame[num_tests], test_bit[num_tests],
                            test_expect[num_tests]);
                if (n == 4) begin
                    cycle_limit += HOLD + 12 +
                                   test_bursts[num_tests] * (BF * 11 * CPB + GAP + 10);
                    num_tests++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = cycle_limit * 2;
        if (num_tests == 0) begin
            $display("No tests found in the data file");
            fail_cnt++;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
logic/uart_pkg.sv
logic/link_test_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/link_sequencer.sv
logic/frame_checker.sv
logic/link_tester_top.sv
tb/tb_link_tester.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_link_tester
FILELIST  = list.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/testdata_link.txt
# bursts  frame  bit  expected_error_count
# frame 0 corrupts nothing, 255 corrupts every frame, bit 8 is the parity bit
2 0 0 0
2 3 5 1
1 2 8 1
2 7 0 1
1 6 2 1
6 255 0 31
